// ==== build.f ====
common/rename_pkg.sv
common/reg_query_if.sv
common/reg_read_if.sv
common/result_bus_if.sv
register_file/rename_lookup.sv
register_file/register_file.sv
design/rename_unit_top.sv
tb/rename_unit_asserts.sv
tb/rename_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rename_unit_tb \
  -f build.f -Mdir obj_dir -o rename_unit_sim

./obj_dir/rename_unit_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== tb/rename_unit_tb.sv ====
module rename_unit_tb;
  import rename_pkg::*;

  logic      global_bus;
  logic      rst_n;
  logic      clear_tag;
  logic      delete_tag;
  logic      rename_ready;
  logic      ren_en     [num_lanes];
  logic      ren_tag    [num_lanes];
  arch_reg_t ren_rd     [num_lanes];
  arch_reg_t ren_rs_1   [num_lanes];
  arch_reg_t ren_rs_2   [num_lanes];
  phys_reg_t ren_rn     [num_lanes];
  logic      ren_ok     [num_lanes];
  phys_reg_t ren_ps_1   [num_lanes];
  phys_reg_t ren_ps_2   [num_lanes];
  phys_reg_t rd_src_1   [num_lanes];
  phys_reg_t rd_src_2   [num_lanes];
  data_t     rd_data_1  [num_lanes];
  logic      rd_valid_1 [num_lanes];
  data_t     rd_data_2  [num_lanes];
  logic      rd_valid_2 [num_lanes];
  logic      wb_write   [num_lanes];
  arch_reg_t wb_arn     [num_lanes];
  phys_reg_t wb_rrn     [num_lanes];
  data_t     wb_result  [num_lanes];

  // Model state
  phys_reg_t m_link  [num_arch_regs];
  logic      m_tag   [num_phys_regs];
  logic      m_valid [num_phys_regs];
  data_t     m_value [num_phys_regs];
  logic      m_free  [num_ren_regs];

  phys_reg_t exp_rn   [num_lanes];
  logic      exp_ok   [num_lanes];
  logic      exp_ren  [num_lanes];
  phys_reg_t exp_ps_1 [num_lanes];
  phys_reg_t exp_ps_2 [num_lanes];
  logic      exp_ready;

  logic [31:0] lcg_state = 32'h2aa1;
  int          phys_errs = 0;
  int          data_errs = 0;
  int          flag_errs = 0;
  int          other_errs = 0;

  rename_unit_top rename_unit_top_inst (.*);

  initial begin
    global_bus = 1'b0;
    forever #50 global_bus = ~global_bus;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic arch_reg_t rand_rd();
    return arch_reg_t'(lcg_next() % 31 + 1);  // Never r0
  endfunction

  // ********************************************************************
  // Reference model
  // ********************************************************************
  function automatic phys_reg_t translate(input arch_reg_t rs);
    phys_reg_t ps;
    ps.idx = {1'b0, rs};
    if ((rs != '0) && (m_link[rs].idx != '0)) ps = m_link[rs];
    return ps;
  endfunction

  function automatic void predict();
    int free_cnt;
    int low [2];
    int k;
    free_cnt = 0;
    low[0] = 0;
    low[1] = 0;
    for (int s = 0; s < num_ren_regs; s++) begin
      if (m_free[s]) begin
        if (free_cnt < 2) low[free_cnt] = s;
        free_cnt++;
      end
    end
    exp_ready     = (free_cnt >= 2);
    exp_ok[0]     = (free_cnt >= 1) && (ren_rd[0] != '0);
    exp_rn[0].idx = 6'(num_arch_regs + low[0]);
    exp_ren[0]    = ren_en[0] && exp_ok[0];
    k             = exp_ren[0] ? 1 : 0;  // Lane 1 moves up past lane 0
    exp_ok[1]     = (free_cnt > k) && (ren_rd[1] != '0);
    exp_rn[1].idx = 6'(num_arch_regs + low[k]);
    exp_ren[1]    = ren_en[1] && exp_ok[1];
    for (int l = 0; l < num_lanes; l++) begin
      exp_ps_1[l] = translate(ren_rs_1[l]);
      exp_ps_2[l] = translate(ren_rs_2[l]);
    end
    if (exp_ren[0] && (ren_rs_1[1] == ren_rd[0])) exp_ps_1[1] = exp_rn[0];
    if (exp_ren[0] && (ren_rs_2[1] == ren_rd[0])) exp_ps_2[1] = exp_rn[0];
  endfunction

  function automatic void advance_model();
    if (!rst_n) begin
      for (int i = 0; i < num_arch_regs; i++) m_link[i] = '0;
      for (int i = 0; i < num_phys_regs; i++) begin
        m_tag[i]   = 1'b0;
        m_valid[i] = (i < num_arch_regs);
        m_value[i] = '0;
      end
      for (int s = 0; s < num_ren_regs; s++) m_free[s] = 1'b1;
    end else if (delete_tag) begin
      for (int i = 0; i < num_phys_regs; i++) begin
        if (m_tag[i] && (i < num_arch_regs)) m_link[i] = '0;
        if (m_tag[i] && (i >= num_arch_regs)) begin
          m_valid[i] = 1'b0;
          m_free[i - num_arch_regs] = 1'b1;
        end
        m_tag[i] = 1'b0;
      end
    end else begin
      if (clear_tag) for (int i = 0; i < num_phys_regs; i++) m_tag[i] = 1'b0;
      for (int p = 0; p < num_lanes; p++) begin
        if (wb_write[p] && (wb_arn[p] == '0)) begin
          m_value[wb_rrn[p].idx] = wb_result[p];
          m_valid[wb_rrn[p].idx] = 1'b1;
        end else if (wb_write[p]) begin
          m_value[wb_arn[p]] = wb_result[p];
          m_valid[wb_arn[p]] = 1'b1;
          if (m_link[wb_arn[p]].idx == wb_rrn[p].idx) begin
            m_link[wb_arn[p]] = '0;
            m_tag[wb_arn[p]]  = 1'b0;
          end
          if (wb_rrn[p].idx >= num_arch_regs) begin
            m_valid[wb_rrn[p].idx] = 1'b0;
            m_tag[wb_rrn[p].idx]   = 1'b0;
            m_free[wb_rrn[p].idx - num_arch_regs] = 1'b1;
          end
        end
      end
      for (int l = 0; l < num_lanes; l++) begin
        if (exp_ren[l]) begin
          m_link[ren_rd[l]]       = exp_rn[l];
          m_valid[exp_rn[l].idx]  = 1'b0;
          m_tag[exp_rn[l].idx]    = ren_tag[l];
          if (ren_tag[l]) m_tag[ren_rd[l]] = 1'b1;
          m_free[exp_rn[l].idx - num_arch_regs] = 1'b0;
        end
      end
    end
  endfunction

  // ********************************************************************
  // Compare tasks and per-cycle checker
  // ********************************************************************
  task automatic check_phys(input string name, input phys_reg_t got, input phys_reg_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got.idx, exp.idx);
      phys_errs++;
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      flag_errs++;
    end
  endtask

  always @(negedge global_bus) begin
    if (rst_n) begin
      predict();
      check_flag("rename_ready", rename_ready, exp_ready);
      for (int l = 0; l < num_lanes; l++) begin
        check_flag($sformatf("ren_ok[%0d]", l), ren_ok[l], exp_ok[l]);
        if (exp_ok[l]) check_phys($sformatf("ren_rn[%0d]", l), ren_rn[l], exp_rn[l]);
        check_phys($sformatf("ren_ps_1[%0d]", l), ren_ps_1[l], exp_ps_1[l]);
        check_phys($sformatf("ren_ps_2[%0d]", l), ren_ps_2[l], exp_ps_2[l]);
        check_flag($sformatf("rd_valid_1[%0d]", l), rd_valid_1[l], m_valid[rd_src_1[l].idx]);
        check_flag($sformatf("rd_valid_2[%0d]", l), rd_valid_2[l], m_valid[rd_src_2[l].idx]);
        if (m_valid[rd_src_1[l].idx]) begin
          check_data($sformatf("rd_data_1[%0d]", l), rd_data_1[l], m_value[rd_src_1[l].idx]);
        end
        if (m_valid[rd_src_2[l].idx]) begin
          check_data($sformatf("rd_data_2[%0d]", l), rd_data_2[l], m_value[rd_src_2[l].idx]);
        end
      end
    end
    advance_model();
  end

  // ********************************************************************
  // Stimulus helpers
  // ********************************************************************
  task automatic next_cycle();
    @(posedge global_bus);
    #10;
    for (int l = 0; l < num_lanes; l++) rd_src_2[l].idx = 6'(lcg_next() >> 10);
  endtask

  task automatic set_lane(input int l, input logic en, input logic tag, input arch_reg_t rd,
                          input arch_reg_t rs_1, input arch_reg_t rs_2);
    ren_en[l]   = en;
    ren_tag[l]  = tag;
    ren_rd[l]   = rd;
    ren_rs_1[l] = rs_1;
    ren_rs_2[l] = rs_2;
  endtask

  task automatic set_result(input int p, input arch_reg_t arn, input int rrn);
    wb_write[p]   = 1'b1;
    wb_arn[p]     = arn;
    wb_rrn[p].idx = 6'(rrn);
    wb_result[p]  = lcg_next();
  endtask

  task automatic go_idle();
    clear_tag  = 1'b0;
    delete_tag = 1'b0;
    for (int l = 0; l < num_lanes; l++) begin
      ren_en[l]   = 1'b0;
      wb_write[l] = 1'b0;
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    go_idle();
    repeat (10) next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic wait_ready();
    int count;
    count = 0;
    while (!rename_ready && (count < 20)) begin
      next_cycle();
      count++;
    end
    if (!rename_ready) begin
      $display("Timed out waiting for rename_ready");
      other_errs++;
    end
  endtask

  // Set up one renaming pair used by both tag runs
  task automatic tagged_pair();
    wait_ready();
    set_lane(0, 1'b1, 1'b0, 5'd3, 5'd0, 5'd0);
    next_cycle();
    set_lane(0, 1'b1, 1'b1, 5'd4, 5'd0, 5'd0);
    set_lane(1, 1'b1, 1'b1, 5'd3, 5'd4, 5'd0);  // Bypass from lane 0
    next_cycle();
    go_idle();
  endtask

  initial begin
    int count;
    int total;
    rst_n      = 1'b0;
    clear_tag  = 1'b0;
    delete_tag = 1'b0;
    for (int l = 0; l < num_lanes; l++) begin
      set_lane(l, 1'b0, 1'b0, '0, '0, '0);
      wb_write[l]  = 1'b0;
      wb_arn[l]    = '0;
      wb_rrn[l]    = '0;
      wb_result[l] = '0;
      rd_src_1[l]  = '0;
      rd_src_2[l]  = '0;
    end
    apply_reset();

    // Fresh pair with a same-cycle bypass, then stored links
    wait_ready();
    set_lane(0, 1'b1, 1'b0, 5'd5, 5'd5, 5'd6);
    set_lane(1, 1'b1, 1'b0, 5'd7, 5'd5, 5'd0);
    next_cycle();
    go_idle();
    set_lane(0, 1'b0, 1'b0, 5'd0, 5'd5, 5'd7);
    set_result(0, 5'd0, 32);  // Writeback into the r5 copy
    next_cycle();
    go_idle();
    rd_src_1[0].idx = 6'd32;
    next_cycle();
    set_result(1, 5'd5, 32);  // Commit r5
    set_lane(0, 1'b1, 1'b0, 5'd7, 5'd7, 5'd0);
    next_cycle();
    go_idle();
    set_lane(0, 1'b1, 1'b0, 5'd9, 5'd5, 5'd7);  // Reuses slot 0
    set_result(0, 5'd7, 33);  // Older r7 copy, newer link stays
    next_cycle();
    go_idle();
    set_lane(1, 1'b0, 1'b0, 5'd0, 5'd7, 5'd9);
    rd_src_1[1].idx = 6'd7;
    next_cycle();

    // Run the free list dry
    wait_ready();
    count = 0;
    set_lane(0, 1'b1, 1'b0, rand_rd(), rand_rd(), rand_rd());
    set_lane(1, 1'b1, 1'b0, rand_rd(), rand_rd(), rand_rd());
    #1;
    while (ren_ok[0] && (count < 40)) begin
      next_cycle();
      count++;
      set_lane(0, 1'b1, 1'b0, rand_rd(), rand_rd(), rand_rd());
      set_lane(1, 1'b1, 1'b0, rand_rd(), rand_rd(), rand_rd());
      #1;
    end
    if (ren_ok[0]) begin
      $display("Timed out waiting for the free list to run out");
      other_errs++;
    end
    check_flag("rename_ready when full", rename_ready, 1'b0);
    next_cycle();

    // Clear keeps every link, a later squash then has nothing to undo
    apply_reset();
    tagged_pair();
    clear_tag = 1'b1;
    next_cycle();
    go_idle();
    set_lane(0, 1'b0, 1'b0, 5'd0, 5'd3, 5'd4);
    next_cycle();
    delete_tag = 1'b1;
    next_cycle();
    go_idle();
    next_cycle();

    // Squash undoes the tagged renames
    apply_reset();
    tagged_pair();
    delete_tag = 1'b1;
    next_cycle();
    go_idle();
    set_lane(0, 1'b1, 1'b0, 5'd6, 5'd3, 5'd4);
    set_lane(1, 1'b1, 1'b0, 5'd8, 5'd0, 5'd0);
    next_cycle();
    go_idle();
    next_cycle();

    total = phys_errs + data_errs + flag_errs + other_errs +
            rename_unit_top_inst.register_file_inst.rename_unit_asserts_inst.fail_count;
    $display("Errors: phys %0d, data %0d, flag %0d, other %0d, assert %0d",
             phys_errs, data_errs, flag_errs, other_errs,
             rename_unit_top_inst.register_file_inst.rename_unit_asserts_inst.fail_count);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/rename_unit_asserts.sv ====
module rename_unit_asserts (
  input logic                                 global_bus,
  input logic                                 rst_n,
  input logic                                 en_0,
  input logic                                 ok_0,
  input logic                                 ok_1,
  input rename_pkg::phys_reg_t                rn_0,
  input rename_pkg::phys_reg_t                rn_1,
  input logic [rename_pkg::num_phys_regs-1:0] reg_valid,
  input logic [rename_pkg::num_ren_regs-1:0]  free_list
);

  int fail_count = 0;

  // Granted numbers are empty rename registers
  rn_bank_0: assert property (@(posedge global_bus) disable iff (!rst_n)
    ok_0 |-> (rn_0.idx >= 6'd32) && !reg_valid[rn_0.idx])
    else begin
      $error("lane 0 granted a number that is not an empty rename register");
      fail_count++;
    end

  rn_bank_1: assert property (@(posedge global_bus) disable iff (!rst_n)
    ok_1 |-> (rn_1.idx >= 6'd32) && !reg_valid[rn_1.idx])
    else begin
      $error("lane 1 granted a number that is not an empty rename register");
      fail_count++;
    end

  rn_distinct: assert property (@(posedge global_bus) disable iff (!rst_n)
    (en_0 && ok_0 && ok_1) |-> (rn_0.idx != rn_1.idx))
    else begin
      $error("both lanes granted the same rename register");
      fail_count++;
    end

  // No slot leaves the free list on an edge without a grant
  ren_needs_ok: assert property (@(posedge global_bus) disable iff (!rst_n)
    (!ok_0 && !ok_1) |=> (($past(free_list) & ~free_list) == '0))
    else begin
      $error("rename taken while ok was low");
      fail_count++;
    end

endmodule

bind register_file rename_unit_asserts rename_unit_asserts_inst (
  .global_bus (global_bus),
  .rst_n      (rst_n),
  .en_0       (query[0].en),
  .ok_0       (query[0].ok),
  .ok_1       (query[1].ok),
  .rn_0       (query[0].rn),
  .rn_1       (query[1].rn),
  .reg_valid  (reg_valid),
  .free_list  (rename_lookup_inst.free_list)
);

// ==== design/rename_unit_top.sv ====
module rename_unit_top (
  input  logic                  global_bus,
  input  logic                  rst_n,
  input  logic                  clear_tag,
  input  logic                  delete_tag,
  output logic                  rename_ready,

  // Rename lanes
  input  logic                  ren_en     [rename_pkg::num_lanes],
  input  logic                  ren_tag    [rename_pkg::num_lanes],
  input  rename_pkg::arch_reg_t ren_rd     [rename_pkg::num_lanes],
  input  rename_pkg::arch_reg_t ren_rs_1   [rename_pkg::num_lanes],
  input  rename_pkg::arch_reg_t ren_rs_2   [rename_pkg::num_lanes],
  output rename_pkg::phys_reg_t ren_rn     [rename_pkg::num_lanes],
  output logic                  ren_ok     [rename_pkg::num_lanes],
  output rename_pkg::phys_reg_t ren_ps_1   [rename_pkg::num_lanes],
  output rename_pkg::phys_reg_t ren_ps_2   [rename_pkg::num_lanes],

  // Operand reads
  input  rename_pkg::phys_reg_t rd_src_1   [rename_pkg::num_lanes],
  input  rename_pkg::phys_reg_t rd_src_2   [rename_pkg::num_lanes],
  output rename_pkg::data_t     rd_data_1  [rename_pkg::num_lanes],
  output logic                  rd_valid_1 [rename_pkg::num_lanes],
  output rename_pkg::data_t     rd_data_2  [rename_pkg::num_lanes],
  output logic                  rd_valid_2 [rename_pkg::num_lanes],

  // Result ports
  input  logic                  wb_write   [rename_pkg::num_lanes],
  input  rename_pkg::arch_reg_t wb_arn     [rename_pkg::num_lanes],
  input  rename_pkg::phys_reg_t wb_rrn     [rename_pkg::num_lanes],
  input  rename_pkg::data_t     wb_result  [rename_pkg::num_lanes]
);
  import rename_pkg::*;

  reg_query_if  query_bus  [num_lanes] ();
  reg_read_if   read_bus   [num_lanes] ();
  result_bus_if result_bus [num_lanes] ();

  for (genvar g = 0; g < num_lanes; g++) begin : gen_wire
    assign query_bus[g].en   = ren_en[g];
    assign query_bus[g].tag  = ren_tag[g];
    assign query_bus[g].rd   = ren_rd[g];
    assign query_bus[g].rs_1 = ren_rs_1[g];
    assign query_bus[g].rs_2 = ren_rs_2[g];
    assign ren_rn[g]         = query_bus[g].rn;
    assign ren_ok[g]         = query_bus[g].ok;
    assign ren_ps_1[g]       = query_bus[g].ps_1;
    assign ren_ps_2[g]       = query_bus[g].ps_2;

    assign read_bus[g].src_1 = rd_src_1[g];
    assign read_bus[g].src_2 = rd_src_2[g];
    assign rd_data_1[g]      = read_bus[g].data_1;
    assign rd_valid_1[g]     = read_bus[g].valid_1;
    assign rd_data_2[g]      = read_bus[g].data_2;
    assign rd_valid_2[g]     = read_bus[g].valid_2;

    assign result_bus[g].reg_write = wb_write[g];
    assign result_bus[g].arn       = wb_arn[g];
    assign result_bus[g].rrn       = wb_rrn[g];
    assign result_bus[g].result    = wb_result[g];
  end

  register_file register_file_inst (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .query        (query_bus),
    .read         (read_bus),
    .result       (result_bus),
    .clear_tag    (clear_tag),
    .delete_tag   (delete_tag),
    .rename_ready (rename_ready)
  );

endmodule

// ==== register_file/register_file.sv ====
module register_file (
  input  logic            global_bus,
  input  logic            rst_n,
  reg_query_if.reg_file   query  [rename_pkg::num_lanes],
  reg_read_if.reg_file    read   [rename_pkg::num_lanes],
  result_bus_if.reg_file  result [rename_pkg::num_lanes],
  input  logic            clear_tag,
  input  logic            delete_tag,
  output logic            rename_ready
);
  import rename_pkg::*;

  // ********************************************************************
  // Storage
  // ********************************************************************
  data_t                    reg_value [num_phys_regs];
  logic [num_phys_regs-1:0] reg_valid;
  logic [num_phys_regs-1:0] reg_tag;
  phys_reg_t                reg_link  [num_arch_regs];  // Zero when not renamed

  logic [num_ren_regs-1:0]  free_set;

  // Lane and port views flattened out of the interfaces
  logic      lane_ren   [num_lanes];
  logic      lane_tag   [num_lanes];
  arch_reg_t lane_rd    [num_lanes];
  phys_reg_t lane_rn    [num_lanes];
  logic      res_write  [num_lanes];
  arch_reg_t res_arn    [num_lanes];
  phys_reg_t res_rrn    [num_lanes];
  data_t     res_value  [num_lanes];

  rename_lookup rename_lookup_inst (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .query        (query),
    .free_set     (free_set),
    .rename_ready (rename_ready)
  );

  function automatic phys_reg_t map_src(input arch_reg_t rs, input phys_reg_t link);
    phys_reg_t ps;
    ps = '0;
    if (rs == '0) begin
      ps.idx = '0;  // r0 is never renamed
    end else if (link.idx != '0) begin
      ps = link;
    end else begin
      ps.idx = {1'b0, rs};
    end
    return ps;
  endfunction

  // ********************************************************************
  // Per lane translation and operand reads
  // ********************************************************************
  for (genvar g = 0; g < num_lanes; g++) begin : gen_lane
    assign lane_ren[g] = query[g].en && query[g].ok;
    assign lane_tag[g] = query[g].tag;
    assign lane_rd[g]  = query[g].rd;
    assign lane_rn[g]  = query[g].rn;

    always_comb begin
      query[g].ps_1 = map_src(query[g].rs_1, reg_link[query[g].rs_1]);
      query[g].ps_2 = map_src(query[g].rs_2, reg_link[query[g].rs_2]);
      // Younger lane sees the older lane's rename in the same cycle
      if ((g != 0) && lane_ren[0] && (query[g].rs_1 == lane_rd[0])) begin
        query[g].ps_1 = lane_rn[0];
      end
      if ((g != 0) && lane_ren[0] && (query[g].rs_2 == lane_rd[0])) begin
        query[g].ps_2 = lane_rn[0];
      end
    end

    assign read[g].data_1  = reg_value[read[g].src_1.idx];
    assign read[g].valid_1 = reg_valid[read[g].src_1.idx];
    assign read[g].data_2  = reg_value[read[g].src_2.idx];
    assign read[g].valid_2 = reg_valid[read[g].src_2.idx];

    assign res_write[g] = result[g].reg_write;
    assign res_arn[g]   = result[g].arn;
    assign res_rrn[g]   = result[g].rrn;
    assign res_value[g] = result[g].result;
  end

  // ********************************************************************
  // Slots returned to the allocator
  // ********************************************************************
  always_comb begin
    free_set = '0;
    if (delete_tag) begin
      free_set = reg_tag[num_phys_regs-1:num_arch_regs];
      // Renames are dropped on a squash, hand their slots straight back
      for (int l = 0; l < num_lanes; l++) begin
        if (lane_ren[l]) free_set[lane_rn[l].ren.slot] = 1'b1;
      end
    end else begin
      for (int p = 0; p < num_lanes; p++) begin
        if (res_write[p] && (res_arn[p] != '0) && res_rrn[p].ren.bank) begin
          free_set[res_rrn[p].ren.slot] = 1'b1;  // Commit
        end
      end
    end
  end

  // ********************************************************************
  // Updates
  // ********************************************************************
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int i = 0; i < num_arch_regs; i++) begin
        reg_value[i] <= '0;
        reg_link[i]  <= '0;
      end
      reg_valid <= {{num_ren_regs{1'b0}}, {num_arch_regs{1'b1}}};
      reg_tag   <= '0;
    end else if (delete_tag) begin
      // Squash
      for (int i = 0; i < num_arch_regs; i++) begin
        if (reg_tag[i]) begin
          reg_tag[i]  <= 1'b0;
          reg_link[i] <= '0;
        end
      end
      for (int i = num_arch_regs; i < num_phys_regs; i++) begin
        if (reg_tag[i]) begin
          reg_tag[i]   <= 1'b0;
          reg_valid[i] <= 1'b0;
        end
      end
    end else begin
      if (clear_tag) reg_tag <= '0;

      for (int p = 0; p < num_lanes; p++) begin
        if (res_write[p]) begin
          if (res_arn[p] == '0) begin
            reg_value[res_rrn[p].idx] <= res_value[p];  // Writeback
            reg_valid[res_rrn[p].idx] <= 1'b1;
          end else begin
            reg_value[res_arn[p]] <= res_value[p];
            reg_valid[res_arn[p]] <= 1'b1;
            // Keep a newer mapping
            if (reg_link[res_arn[p]].idx == res_rrn[p].idx) begin
              reg_link[res_arn[p]] <= '0;
              reg_tag[res_arn[p]]  <= 1'b0;
            end
            if (res_rrn[p].ren.bank) begin
              reg_valid[res_rrn[p].idx] <= 1'b0;
              reg_tag[res_rrn[p].idx]   <= 1'b0;
            end
          end
        end
      end

      // Renames last so a same-edge rename of arn keeps its new link
      for (int l = 0; l < num_lanes; l++) begin
        if (lane_ren[l]) begin
          reg_link[lane_rd[l]]      <= lane_rn[l];
          reg_valid[lane_rn[l].idx] <= 1'b0;
          reg_tag[lane_rn[l].idx]   <= lane_tag[l];
          if (lane_tag[l]) reg_tag[lane_rd[l]] <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== register_file/rename_lookup.sv ====
module rename_lookup (
  input  logic                                global_bus,
  input  logic                                rst_n,
  reg_query_if.alloc                          query [rename_pkg::num_lanes],
  input  logic [rename_pkg::num_ren_regs-1:0] free_set,
  output logic                                rename_ready
);
  import rename_pkg::*;

  logic [num_ren_regs-1:0] free_list;
  logic [num_ren_regs-1:0] free_rest;
  logic [num_ren_regs-1:0] alloc_mask;
  phys_reg_t               first;
  phys_reg_t               second;
  logic                    ren_0;
  logic                    ren_1;

  // Lowest set bit as a rename number, bank bit doubles as the hit flag
  function automatic phys_reg_t find_low(input logic [num_ren_regs-1:0] mask);
    phys_reg_t hit;
    hit = '0;
    for (int i = num_ren_regs - 1; i >= 0; i--) begin
      if (mask[i]) begin
        hit.ren.bank = 1'b1;
        hit.ren.slot = i[4:0];
      end
    end
    return hit;
  endfunction

  // ********************************************************************
  // Priority encode the two lowest free slots
  // ********************************************************************
  assign first     = find_low(free_list);
  assign free_rest = free_list & ~(num_ren_regs'(1) << first.ren.slot);
  assign second    = find_low(free_rest);

  assign rename_ready = second.ren.bank;  // Two or more free

  // Lane 0 always gets the lowest slot
  assign query[0].rn = first;
  assign query[0].ok = first.ren.bank && (query[0].rd != '0);
  assign ren_0       = query[0].en && query[0].ok;

  // Lane 1 moves up one slot only if lane 0 takes one
  assign query[1].rn = ren_0 ? second : first;
  assign query[1].ok = query[1].rn.ren.bank && (query[1].rd != '0);
  assign ren_1       = query[1].en && query[1].ok;

  always_comb begin
    alloc_mask = '0;
    if (ren_0) alloc_mask[first.ren.slot] = 1'b1;
    if (ren_1) alloc_mask[query[1].rn.ren.slot] = 1'b1;
  end

  // ********************************************************************
  // Free list
  // ********************************************************************
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      free_list <= '1;
    end else begin
      free_list <= (free_list & ~alloc_mask) | free_set;
    end
  end

endmodule

// ==== common/result_bus_if.sv ====
interface result_bus_if;
  import rename_pkg::*;

  logic      reg_write;
  arch_reg_t arn;     // Zero for an execution writeback
  phys_reg_t rrn;
  data_t     result;

  modport front (
    output reg_write, arn, rrn, result
  );

  modport reg_file (
    input reg_write, arn, rrn, result
  );

endinterface

// ==== common/reg_read_if.sv ====
interface reg_read_if;
  import rename_pkg::*;

  phys_reg_t src_1;
  phys_reg_t src_2;
  data_t     data_1;
  logic      valid_1;
  data_t     data_2;
  logic      valid_2;

  modport front (
    output src_1, src_2,
    input  data_1, valid_1, data_2, valid_2
  );

  modport reg_file (
    input  src_1, src_2,
    output data_1, valid_1, data_2, valid_2
  );

endinterface

// ==== common/reg_query_if.sv ====
interface reg_query_if;
  import rename_pkg::*;

  logic      en;
  logic      tag;    // Speculative rename
  arch_reg_t rd;
  arch_reg_t rs_1;
  arch_reg_t rs_2;
  phys_reg_t rn;
  logic      ok;
  phys_reg_t ps_1;
  phys_reg_t ps_2;

  modport front (
    output en, tag, rd, rs_1, rs_2,
    input  rn, ok, ps_1, ps_2
  );

  modport alloc (
    input  en, rd,
    output rn, ok
  );

  modport reg_file (
    input  en, tag, rd, rs_1, rs_2, rn, ok,
    output ps_1, ps_2
  );

endinterface

// ==== common/rename_pkg.sv ====
package rename_pkg;

  // ********************************************************************
  // Sizes
  // ********************************************************************
  localparam int num_lanes     = 2;
  localparam int num_arch_regs = 32;
  localparam int num_ren_regs  = 32;
  localparam int num_phys_regs = num_arch_regs + num_ren_regs;
  localparam int data_w        = 32;

  // ********************************************************************
  // Register numbers and values
  // ********************************************************************
  typedef logic [4:0] arch_reg_t;

  // Rename view of a physical number
  typedef struct packed {
    logic       bank;  // Set for rename registers
    logic [4:0] slot;  // Free list bit
  } phys_slot_t;

  // Same six bits, either as a flat index or as bank and slot
  typedef union packed {
    logic [5:0] idx;
    phys_slot_t ren;
  } phys_reg_t;

  typedef logic [data_w-1:0] data_t;

endpackage
